/* verilog/rename_pkg.sv */
// Shared sizes, tag types and reset values for the rename and retire logic
package rename_pkg;

	// Register file sizes
	parameter int ARCH_REGS = 32; // Architectural registers
	parameter int PHYS_REGS = 64; // Physical registers

	parameter int ARCH_W = $clog2(ARCH_REGS);
	parameter int TAG_W  = $clog2(PHYS_REGS);

	// Default reorder buffer depth, overridden from the top
	parameter int DEFAULT_ROB_SIZE = 16;

	// Architectural register number
	typedef logic [ARCH_W-1:0] arch_reg_t;

	// Physical register tag
	typedef logic [TAG_W-1:0] phys_tag_t;

	// Tags above the identity block start out free
	parameter int FIRST_FREE_TAG = ARCH_REGS;

	// Retire side state, HALTED is sticky until reset
	typedef enum logic {
		RUNNING,
		HALTED
	} retire_state_t;

	// Reset mapping is the identity, arch r -> tag r
	function automatic phys_tag_t reset_tag(input int r);
		phys_tag_t t;
		t = phys_tag_t'(r);
		return t;
	endfunction

endpackage

/* verilog/free_list.sv */
`timescale 1ns/1ps

// Free physical tags kept as one bit per tag, lowest free tag goes out first
module free_list (
	input  logic                                              clock,
	input  logic                                              rst,
	input  logic                                              alloc,       // Dispatch takes alloc_tag
	output rename_pkg::phys_tag_t                             alloc_tag,
	output logic                                              alloc_ok,    // At least one tag free
	input  logic                                              release_en,  // Retire frees a tag
	input  rename_pkg::phys_tag_t                             release_tag,
	input  logic                                              flush,
	input  rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] arch_table
);

	logic [rename_pkg::PHYS_REGS-1:0] free_vec;  // 1 = tag is free
	logic [rename_pkg::PHYS_REGS-1:0] flush_vec; // Rebuilt vector for recovery

	// Priority search, the loop runs downward so the lowest hit wins
	always_comb begin
		alloc_tag = '0;
		for (int t = rename_pkg::PHYS_REGS - 1; t >= 0; t--) begin
			if (free_vec[t])
				alloc_tag = rename_pkg::phys_tag_t'(t);
		end
	end

	assign alloc_ok = |free_vec;

	// Every tag that the committed map does not hold is free after flush
	always_comb begin
		flush_vec = '1;
		for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
			flush_vec[arch_table[r]] = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int t = 0; t < rename_pkg::PHYS_REGS; t++) begin
				free_vec[t] <= (t >= rename_pkg::FIRST_FREE_TAG); // Upper half free
			end
		end else if (flush) begin
			free_vec <= flush_vec;
		end else begin
			if (alloc && alloc_ok)
				free_vec[alloc_tag] <= 1'b0; // Tag now in flight
			// Released tag is never the one being allocated, it was busy until now
			if (release_en)
				free_vec[release_tag] <= 1'b1;
		end
	end

	// A retired old tag must still be owned by the pipeline
	a_release_busy: assert property (
		@(posedge clock) disable iff (rst)
		release_en && !flush |-> !free_vec[release_tag]
	) else $error("free_list: tag %0d released while already free", release_tag);

endmodule

/* verilog/map_table.sv */
`timescale 1ns/1ps

// Speculative arch -> phys map, written at dispatch
module map_table (
	input  logic                                              clock,
	input  logic                                              rst,
	input  logic                                              disp_fire,
	input  rename_pkg::arch_reg_t                             disp_arch, // Destination register
	input  rename_pkg::phys_tag_t                             new_tag,   // From the free list
	output rename_pkg::phys_tag_t                             old_tag,   // Mapping before this dispatch
	input  logic                                              flush,
	input  rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] arch_table
);

	rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] map;

	// Previous mapping is read in the dispatch cycle itself
	assign old_tag = map[disp_arch];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
				map[r] <= rename_pkg::reset_tag(r); // Identity
			end
		end else if (flush) begin
			map <= arch_table; // Back to the committed state
		end else if (disp_fire) begin
			map[disp_arch] <= new_tag;
		end
	end

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps

// Circular reorder buffer holding program order from tail (dispatch) to head (retire)
module reorder_buffer #(
	parameter int ROB_SIZE = rename_pkg::DEFAULT_ROB_SIZE
) (
	input  logic                          clock,
	input  logic                          rst,
	input  logic                          flush,
	input  logic                          disp_fire,
	input  rename_pkg::arch_reg_t         disp_arch,
	input  rename_pkg::phys_tag_t         disp_tag,
	input  rename_pkg::phys_tag_t         disp_old_tag,
	input  logic                          disp_halt,
	input  logic                          cdb_valid,
	input  rename_pkg::phys_tag_t         cdb_tag,
	output logic                          full,
	output logic [$clog2(ROB_SIZE):0]     count,
	output logic                          head_valid,   // Oldest entry is done
	output rename_pkg::arch_reg_t         head_arch,
	output rename_pkg::phys_tag_t         head_tag,
	output rename_pkg::phys_tag_t         head_old_tag,
	output logic                          head_halt,
	input  logic                          retire_fire
);

	localparam int IDX_W = $clog2(ROB_SIZE);

	// Entry control bits
	logic [ROB_SIZE-1:0] busy;
	logic [ROB_SIZE-1:0] complete;

	// Entry payload qualified by busy
	logic                  halt_q   [ROB_SIZE];
	rename_pkg::arch_reg_t arch_q   [ROB_SIZE];
	rename_pkg::phys_tag_t tag_q    [ROB_SIZE];
	rename_pkg::phys_tag_t old_tag_q[ROB_SIZE];

	logic [IDX_W-1:0] head;
	logic [IDX_W-1:0] tail;

	logic [ROB_SIZE-1:0] cdb_hit; // Completion tag match per entry

	// Wrap explicitly so depths that are not a power of two also work
	function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
		logic [IDX_W-1:0] n;
		if (idx == IDX_W'(ROB_SIZE - 1))
			n = '0;
		else
			n = idx + 1'b1;
		return n;
	endfunction

	// Tag match against every waiting entry
	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) begin
			cdb_hit[i] = cdb_valid && busy[i] && !complete[i] && (tag_q[i] == cdb_tag);
		end
	end

	assign full = (count == (IDX_W + 1)'(ROB_SIZE));

	// Head view for the retire side
	assign head_valid   = busy[head] && complete[head];
	assign head_arch    = arch_q[head];
	assign head_tag     = tag_q[head];
	assign head_old_tag = old_tag_q[head];
	assign head_halt    = halt_q[head];

	// Control state
	always_ff @(posedge clock) begin
		if (rst || flush) begin
			busy     <= '0; // Drop everything in flight
			complete <= '0;
			head     <= '0;
			tail     <= '0;
			count    <= '0;
		end else begin
			complete <= complete | cdb_hit;
			if (retire_fire) begin
				busy[head]     <= 1'b0;
				complete[head] <= 1'b0;
				head           <= next_idx(head);
			end
			// Tail slot is free so a same-cycle completion cannot hit it
			if (disp_fire) begin
				busy[tail]     <= 1'b1;
				complete[tail] <= 1'b0;
				tail           <= next_idx(tail);
			end
			case ({disp_fire, retire_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Payload written at the tail
	always_ff @(posedge clock) begin
		if (disp_fire) begin
			arch_q[tail]    <= disp_arch;
			tag_q[tail]     <= disp_tag;
			old_tag_q[tail] <= disp_old_tag;
			halt_q[tail]    <= disp_halt;
		end
	end

	// Top level gating must keep dispatch away from a full buffer
	a_no_disp_full: assert property (
		@(posedge clock) disable iff (rst)
		disp_fire |-> !full
	) else $error("reorder_buffer: dispatch while full");

	// Retire side may only fire on a finished head entry
	a_retire_head: assert property (
		@(posedge clock) disable iff (rst)
		retire_fire |-> head_valid
	) else $error("reorder_buffer: retire without a valid head");

endmodule

/* verilog/arch_map.sv */
`timescale 1ns/1ps

// Committed map and retire handshake
module arch_map (
	input  logic                                              clock,
	input  logic                                              rst,
	input  logic                                              flush,
	input  logic                                              head_valid,
	input  rename_pkg::arch_reg_t                             head_arch,
	input  rename_pkg::phys_tag_t                             head_tag,
	input  logic                                              head_halt,
	input  logic                                              retire_ready,
	output logic                                              retire_valid,
	output logic                                              retire_fire,
	output rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] arch_table,
	output logic                                              halted
);

	rename_pkg::retire_state_t state;

	// Nothing retires once halted or while a flush is pending
	assign retire_valid = head_valid && (state == rename_pkg::RUNNING) && !flush;
	assign retire_fire  = retire_valid && retire_ready;
	assign halted       = (state == rename_pkg::HALTED);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
				arch_table[r] <= rename_pkg::reset_tag(r);
			end
		end else if (retire_fire) begin
			arch_table[head_arch] <= head_tag; // Head's new tag becomes committed
		end
	end

	// Halt state, left only through reset
	always_ff @(posedge clock) begin
		if (rst)
			state <= rename_pkg::RUNNING;
		else if (retire_fire && head_halt)
			state <= rename_pkg::HALTED;
	end

endmodule

/* verilog/rename_core.sv */
`timescale 1ns/1ps

// Rename and in-order retire with one instruction per cycle each way
module rename_core #(
	parameter int ROB_SIZE = rename_pkg::DEFAULT_ROB_SIZE
) (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  disp_valid,
	output logic                  disp_ready,
	input  rename_pkg::arch_reg_t disp_arch,
	input  logic                  disp_halt,
	output rename_pkg::phys_tag_t disp_tag,     // Newly allocated tag
	output rename_pkg::phys_tag_t disp_old_tag, // Tag being replaced
	input  logic                  cdb_valid,
	input  rename_pkg::phys_tag_t cdb_tag,
	output logic                  retire_valid,
	input  logic                  retire_ready,
	output rename_pkg::arch_reg_t retire_arch,
	output rename_pkg::phys_tag_t retire_tag,
	output rename_pkg::phys_tag_t retire_old_tag,
	output logic                  retire_halt,
	output logic                  halted
);

	logic                                              disp_fire;
	logic                                              retire_fire;
	logic                                              alloc_ok;
	logic                                              rob_full;
	logic [$clog2(ROB_SIZE):0]                         rob_count;
	logic                                              head_valid;
	rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] arch_table; // Committed map

	// Dispatch handshake
	assign disp_ready = !rob_full && alloc_ok && !flush && !halted;
	assign disp_fire  = disp_valid && disp_ready;

	free_list u_free_list (
		.clock(clock), .rst(rst),
		.alloc(disp_fire), .alloc_tag(disp_tag), .alloc_ok(alloc_ok),
		.release_en(retire_fire), .release_tag(retire_old_tag), // Old tag freed at retire
		.flush(flush), .arch_table(arch_table)
	);

	map_table u_map_table (
		.clock(clock), .rst(rst),
		.disp_fire(disp_fire), .disp_arch(disp_arch),
		.new_tag(disp_tag), .old_tag(disp_old_tag),
		.flush(flush), .arch_table(arch_table)
	);

	reorder_buffer #(.ROB_SIZE(ROB_SIZE)) u_rob (
		.clock(clock), .rst(rst), .flush(flush),
		.disp_fire(disp_fire), .disp_arch(disp_arch), .disp_tag(disp_tag),
		.disp_old_tag(disp_old_tag), .disp_halt(disp_halt),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
		.full(rob_full), .count(rob_count),
		.head_valid(head_valid), .head_arch(retire_arch), .head_tag(retire_tag),
		.head_old_tag(retire_old_tag), .head_halt(retire_halt),
		.retire_fire(retire_fire)
	);

	arch_map u_arch_map (
		.clock(clock), .rst(rst), .flush(flush),
		.head_valid(head_valid), .head_arch(retire_arch), .head_tag(retire_tag),
		.head_halt(retire_halt), .retire_ready(retire_ready),
		.retire_valid(retire_valid), .retire_fire(retire_fire),
		.arch_table(arch_table), .halted(halted)
	);

	// Retire side only offers entries that the buffer actually holds
	a_retire_occupied: assert property (
		@(posedge clock) disable iff (rst)
		retire_valid |-> (rob_count != '0)
	) else $error("rename_core: retire offered from an empty buffer");

endmodule

/* tests/rename_core_tb.sv */
`timescale 1ns/1ps

// Testbench for rename_core with the model moving at the rising edge and checks at the falling edge
module rename_core_tb;

	localparam int ROB_SIZE   = rename_pkg::DEFAULT_ROB_SIZE;
	localparam int MAX_CYCLES = 4000; // Phases add up to about 2300 cycles

	logic                  clock;
	logic                  rst;
	logic                  flush;
	logic                  disp_valid;
	logic                  disp_ready;
	rename_pkg::arch_reg_t disp_arch;
	logic                  disp_halt;
	rename_pkg::phys_tag_t disp_tag;
	rename_pkg::phys_tag_t disp_old_tag;
	logic                  cdb_valid;
	rename_pkg::phys_tag_t cdb_tag;
	logic                  retire_valid;
	logic                  retire_ready;
	rename_pkg::arch_reg_t retire_arch;
	rename_pkg::phys_tag_t retire_tag;
	rename_pkg::phys_tag_t retire_old_tag;
	logic                  retire_halt;
	logic                  halted;

	// Reference model
	rename_pkg::phys_tag_t            spec_map[rename_pkg::ARCH_REGS];
	rename_pkg::phys_tag_t            arch_m[rename_pkg::ARCH_REGS];
	logic [rename_pkg::PHYS_REGS-1:0] in_use;  // Tags held by a map or in flight
	rename_pkg::arch_reg_t            q_arch[$]; // In-flight entries in program order
	rename_pkg::phys_tag_t            q_tag[$];
	rename_pkg::phys_tag_t            q_old[$];
	logic                             q_halt[$];
	logic                             q_done[$];
	logic                             halted_m;
	logic                             fresh;   // First cycle out of reset

	// Model view for the current cycle
	logic                  room;
	logic                  free_any;
	logic                  front_done;
	logic                  front_halt;
	rename_pkg::arch_reg_t front_arch;
	rename_pkg::phys_tag_t front_tag;
	rename_pkg::phys_tag_t front_old;
	rename_pkg::phys_tag_t low_free; // Next tag to hand out
	logic                  exp_disp_ready;
	logic                  exp_retire_valid;
	int                    cycle_count = 0;

	assign exp_disp_ready   = room && free_any && !flush && !halted_m;
	assign exp_retire_valid = front_done && !halted_m && !flush;

	rename_core #(.ROB_SIZE(ROB_SIZE)) dut (
		.clock(clock), .rst(rst), .flush(flush),
		.disp_valid(disp_valid), .disp_ready(disp_ready), .disp_arch(disp_arch),
		.disp_halt(disp_halt), .disp_tag(disp_tag), .disp_old_tag(disp_old_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_arch(retire_arch), .retire_tag(retire_tag),
		.retire_old_tag(retire_old_tag), .retire_halt(retire_halt), .halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	task automatic stop_with_fail(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic report_value(input string name, input int got, input int expected);
		stop_with_fail($sformatf("Fail at %0t: %s = %0d, expected %0d", $time, name, got,
			expected));
	endtask

	// Derived values that the checks and the stimulus read
	task automatic recompute_view();
		logic found;
		found      = 1'b0;
		room       = q_tag.size() < ROB_SIZE;
		front_done = 1'b0;
		if (q_tag.size() > 0) begin
			front_done = q_done[0];
			front_arch = q_arch[0];
			front_tag  = q_tag[0];
			front_old  = q_old[0];
			front_halt = q_halt[0];
		end
		free_any = ~&in_use;
		low_free = '0;
		for (int t = 0; t < rename_pkg::PHYS_REGS; t++) begin
			if (!found && !in_use[t]) begin
				low_free = rename_pkg::phys_tag_t'(t); // Lowest free tag goes first
				found    = 1'b1;
			end
		end
	endtask

	task automatic update_model();
		logic disp_go;
		logic ret_go;
		disp_go = disp_valid && exp_disp_ready; // Both taken before anything moves
		ret_go  = exp_retire_valid && retire_ready;
		if (rst) begin
			for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
				spec_map[r] = rename_pkg::phys_tag_t'(r); // Identity
				arch_m[r]   = rename_pkg::phys_tag_t'(r);
			end
			for (int t = 0; t < rename_pkg::PHYS_REGS; t++)
				in_use[t] = (t < rename_pkg::ARCH_REGS);
			halted_m = 1'b0;
		end
		if (rst || flush) begin
			q_arch.delete();
			q_tag.delete();
			q_old.delete();
			q_halt.delete();
			q_done.delete();
		end
		if (!rst && flush) begin
			spec_map = arch_m; // Back to the committed map
			in_use   = '0;
			for (int r = 0; r < rename_pkg::ARCH_REGS; r++)
				in_use[arch_m[r]] = 1'b1;
		end else if (!rst) begin
			if (cdb_valid) begin
				for (int i = 0; i < q_tag.size(); i++)
					if (q_tag[i] == cdb_tag)
						q_done[i] = 1'b1;
			end
			if (ret_go) begin
				arch_m[front_arch] = front_tag;
				in_use[front_old]  = 1'b0; // Old tag back to the pool
				if (front_halt)
					halted_m = 1'b1;
				void'(q_arch.pop_front());
				void'(q_tag.pop_front());
				void'(q_old.pop_front());
				void'(q_halt.pop_front());
				void'(q_done.pop_front());
			end
			if (disp_go) begin
				q_arch.push_back(disp_arch);
				q_tag.push_back(low_free);
				q_old.push_back(spec_map[disp_arch]);
				q_halt.push_back(disp_halt);
				q_done.push_back(1'b0);
				spec_map[disp_arch] = low_free;
				in_use[low_free]    = 1'b1;
			end
		end
		fresh = rst;
		recompute_view();
	endtask

	always @(posedge clock)
		update_model();

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			stop_with_fail($sformatf("Timeout: run passed %0d cycles", MAX_CYCLES));
	end

	a_idle_after_reset: assert property (@(negedge clock) disable iff (rst)
		fresh |-> disp_ready && !retire_valid && !halted)
		else stop_with_fail("DUT is not idle after reset");
	a_first_tag: assert property (@(negedge clock) disable iff (rst)
		fresh |-> disp_tag == rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS))
		else report_value("disp_tag", disp_tag, rename_pkg::ARCH_REGS);
	a_disp_ready: assert property (@(negedge clock) disable iff (rst)
		disp_ready == exp_disp_ready)
		else report_value("disp_ready", disp_ready, exp_disp_ready);
	a_old_tag: assert property (@(negedge clock) disable iff (rst)
		disp_valid |-> disp_old_tag == spec_map[disp_arch])
		else report_value("disp_old_tag", disp_old_tag, spec_map[disp_arch]);
	a_new_tag: assert property (@(negedge clock) disable iff (rst)
		disp_valid && exp_disp_ready |-> disp_tag == low_free)
		else report_value("disp_tag", disp_tag, low_free);
	a_retire_valid: assert property (@(negedge clock) disable iff (rst)
		retire_valid == exp_retire_valid)
		else report_value("retire_valid", retire_valid, exp_retire_valid);
	a_retire_arch: assert property (@(negedge clock) disable iff (rst)
		retire_valid |-> retire_arch == front_arch)
		else report_value("retire_arch", retire_arch, front_arch);
	a_retire_tag: assert property (@(negedge clock) disable iff (rst)
		retire_valid |-> retire_tag == front_tag)
		else report_value("retire_tag", retire_tag, front_tag);
	a_retire_old: assert property (@(negedge clock) disable iff (rst)
		retire_valid |-> retire_old_tag == front_old)
		else report_value("retire_old_tag", retire_old_tag, front_old);
	a_retire_halt: assert property (@(negedge clock) disable iff (rst)
		retire_valid |-> retire_halt == front_halt)
		else report_value("retire_halt", retire_halt, front_halt);
	// Stalled head must hold still until taken
	a_retire_hold: assert property (@(negedge clock) disable iff (rst)
		retire_valid && !retire_ready |=> flush || (retire_valid && $stable(retire_tag)
			&& $stable(retire_arch) && $stable(retire_old_tag) && $stable(retire_halt)))
		else stop_with_fail("Retire fields changed while retire_ready was low");
	a_halted: assert property (@(negedge clock) disable iff (rst)
		halted == halted_m)
		else report_value("halted", halted, halted_m);

	task automatic next_cycle();
		@(posedge clock);
		#1; // Drive just after the edge
	endtask

	// Random inputs for one cycle with completions only for waiting in-flight entries
	task automatic drive_cycle(input int disp_pct, input int ret_pct, input int cdb_pct);
		int open_idx[$];
		int pick;
		disp_valid   = ($urandom % 100) < disp_pct;
		disp_arch    = rename_pkg::arch_reg_t'($urandom % rename_pkg::ARCH_REGS);
		disp_halt    = 1'b0;
		retire_ready = ($urandom % 100) < ret_pct;
		cdb_valid    = 1'b0;
		cdb_tag      = '0;
		for (int i = 0; i < q_tag.size(); i++)
			if (!q_done[i])
				open_idx.push_back(i);
		if (open_idx.size() > 0 && ($urandom % 100) < cdb_pct) begin
			pick      = open_idx[$urandom % open_idx.size()];
			cdb_valid = 1'b1;
			cdb_tag   = q_tag[pick];
		end
	endtask

	initial begin
		void'($urandom(30));
		rst          = 1'b1;
		flush        = 1'b0;
		disp_valid   = 1'b0;
		disp_arch    = '0;
		disp_halt    = 1'b0;
		cdb_valid    = 1'b0;
		cdb_tag      = '0;
		retire_ready = 1'b0;
		repeat (4) @(posedge clock);
		#1 rst = 1'b0;
		// Mixed traffic
		repeat (1500) begin
			drive_cycle(70, 70, 50);
			next_cycle();
		end
		// Buffer fills with retire stalled and then drains
		repeat (ROB_SIZE + 8) begin
			drive_cycle(100, 0, 60);
			next_cycle();
		end
		repeat (60) begin
			drive_cycle(0, 100, 100);
			next_cycle();
		end
		// Flush rounds with traffic in between
		repeat (12) begin
			repeat (50) begin
				drive_cycle(70, 60, 50);
				next_cycle();
			end
			drive_cycle(70, 60, 50);
			flush = 1'b1;
			next_cycle();
			flush = 1'b0;
		end
		// Every register renamed once after the last flush
		for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
			drive_cycle(100, 100, 80);
			disp_arch = rename_pkg::arch_reg_t'(r);
			next_cycle();
		end
		// Empty the buffer and send a halt
		while (q_tag.size() > 0 || !exp_disp_ready) begin
			drive_cycle(0, 100, 100);
			next_cycle();
		end
		drive_cycle(0, 100, 0);
		disp_valid = 1'b1;
		disp_halt  = 1'b1;
		next_cycle();
		while (!halted) begin
			drive_cycle(40, 100, 100);
			next_cycle();
		end
		repeat (20) begin
			drive_cycle(100, 100, 100); // Dispatch must stay blocked
			next_cycle();
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

/* list.f */
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/reorder_buffer.sv
verilog/arch_map.sv
verilog/rename_core.sv
tests/rename_core_tb.sv

/* Makefile */
# Verilator build and run of the rename core testbench
VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
